// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tb_pacman_core
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
+incdir+verif
source/pacman_pkg.sv
source/game_step_ctrl.sv
source/player_mover.sv
source/ghost_walker.sv
source/ghost_collision.sv
source/pacman_core.sv
verif/tb_pacman_core.sv

// File: source/game_step_ctrl.sv
`timescale 1ns/100ps

module game_step_ctrl (
    input  logic clock,
    input  logic resetn,
    input  logic tick,
    output logic move,
    output logic ghost_step,
    output logic check,
    output logic step_done
);

    import pacman_pkg::*;

    logic [ST_W-1:0] state;

    // Fixed phase chain: idle -> step -> settle -> check -> idle
    // Every output is a registered single-cycle pulse
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            move       <= 1'b0;
            ghost_step <= 1'b0;
            check      <= 1'b0;
            step_done  <= 1'b0;
        end else begin
            // Default low, pulses last one cycle
            move       <= 1'b0;
            ghost_step <= 1'b0;
            check      <= 1'b0;
            step_done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tick) begin   // Only accepted here
                        state      <= ST_STEP;
                        move       <= 1'b1;
                        ghost_step <= 1'b1;
                    end
                end
                ST_STEP: begin
                    state <= ST_SETTLE;   // Player and indices update now
                end
                ST_SETTLE: begin
                    // Walker words are valid after this edge
                    state <= ST_CHECK;
                    check <= 1'b1;
                end
                ST_CHECK: begin
                    state     <= ST_IDLE;   // Collided registers now
                    step_done <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/ghost_collision.sv
`timescale 1ns/100ps

module ghost_collision (
    input  logic                                              clock,
    input  logic                                              resetn,
    input  logic                                              check,
    input  logic [pacman_pkg::X_W-1:0]                        player_x,
    input  logic [pacman_pkg::Y_W-1:0]                        player_y,
    input  logic [pacman_pkg::NUM_GHOSTS*pacman_pkg::X_W-1:0] ghost_x,
    input  logic [pacman_pkg::NUM_GHOSTS*pacman_pkg::Y_W-1:0] ghost_y,
    output logic                                              collided
);

    import pacman_pkg::*;

    logic hit;   // Any ghost on the player tile

    // Both coordinates must match for one ghost
    always_comb begin
        hit = 1'b0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            if (ghost_x[g*X_W +: X_W] == player_x &&
                ghost_y[g*Y_W +: Y_W] == player_y)
                hit = 1'b1;
        end
    end

    // Sampled once per step, held until the next check
    always_ff @(posedge clock) begin
        if (!resetn)
            collided <= 1'b0;
        else if (check)
            collided <= hit;
    end

endmodule

// File: source/ghost_paths.mem
// One path word per line, hex: x in bits 10:6, y in bits 5:2, bits 1:0 spare
// Ghost 0 at 0, ghost 1 at 24, ghost 2 at 56, each a closed loop of tiles
// Ghost 0, 24 entries, loop over x 5..13, y 3..7
14C
18C
1CC
20C
24C
28C
2CC
30C
34C
350
354
358
35C
31C
2DC
29C
25C
21C
1DC
19C
15C
158
154
150
// Ghost 1, 32 entries, loop over x 15..27, y 7..11
3DC
41C
45C
49C
4DC
51C
55C
59C
5DC
61C
65C
69C
6DC
6E0
6E4
6E8
6EC
6AC
66C
62C
5EC
5AC
56C
52C
4EC
4AC
46C
42C
3EC
3E8
3E4
3E0
// Ghost 2, 20 entries, loop over x 1..7, y 6..10
058
098
0D8
118
158
198
1D8
1DC
1E0
1E4
1E8
1A8
168
128
0E8
0A8
068
064
060
05C

// File: source/ghost_walker.sv
`timescale 1ns/100ps

module ghost_walker #(
    parameter int ghost_id = 0   // Selects length and base in the path file
) (
    input  logic                       clock,
    input  logic                       resetn,
    input  logic                       ghost_step,
    output logic [pacman_pkg::X_W-1:0] ghost_x,
    output logic [pacman_pkg::Y_W-1:0] ghost_y
);

    import pacman_pkg::*;

    path_word_t path_table [PATH_DEPTH];   // All ghosts, back to back
    path_word_t path_word;                 // Registered read
    logic [IDX_W-1:0]       path_idx;
    logic [PATH_ADDR_W-1:0] path_addr;

    initial begin
        $readmemh(PATH_FILE, path_table);
    end

    // Step along this ghost's loop, wrap at its own length
    always_ff @(posedge clock) begin
        if (!resetn) begin
            path_idx <= '0;
        end else if (ghost_step) begin
            if (path_idx == IDX_W'(PATH_LEN[ghost_id] - 1))
                path_idx <= '0;
            else
                path_idx <= path_idx + 1'b1;
        end
    end

    // Offset into the shared table
    assign path_addr = PATH_ADDR_W'(PATH_BASE[ghost_id]) + PATH_ADDR_W'(path_idx);

    // Read every cycle, so the tile trails the index by one edge
    always_ff @(posedge clock) begin
        path_word.raw <= path_table[path_addr].raw;
    end

    // Field view of the word
    assign ghost_x = path_word.f.x;
    assign ghost_y = path_word.f.y;

endmodule

// File: source/pacman_core.sv
`timescale 1ns/100ps

module pacman_core (
    input  logic                                              clock,
    input  logic                                              resetn,
    input  logic                                              tick,        // One game step
    input  logic [pacman_pkg::DIR_W-1:0]                      direction,
    output logic [pacman_pkg::X_W-1:0]                        player_x,
    output logic [pacman_pkg::Y_W-1:0]                        player_y,
    output logic [pacman_pkg::NUM_GHOSTS*pacman_pkg::X_W-1:0] ghost_x,     // Ghost 0 low
    output logic [pacman_pkg::NUM_GHOSTS*pacman_pkg::Y_W-1:0] ghost_y,
    output logic                                              collided,
    output logic                                              step_done    // Step finished
);

    import pacman_pkg::*;

    // Phase pulses from the sequencer
    logic move;
    logic ghost_step;
    logic check;

    game_step_ctrl game_step_ctrl_inst (
        .clock      (clock),
        .resetn     (resetn),
        .tick       (tick),
        .move       (move),
        .ghost_step (ghost_step),
        .check      (check),
        .step_done  (step_done)
    );

    player_mover player_mover_inst (
        .clock     (clock),
        .resetn    (resetn),
        .move      (move),
        .direction (direction),
        .player_x  (player_x),
        .player_y  (player_y)
    );

    // One walker per ghost, each on its own slice
    genvar g;
    generate
        for (g = 0; g < NUM_GHOSTS; g++) begin : gen_ghost
            ghost_walker #(
                .ghost_id (g)
            ) ghost_walker_inst (
                .clock      (clock),
                .resetn     (resetn),
                .ghost_step (ghost_step),
                .ghost_x    (ghost_x[g*X_W +: X_W]),
                .ghost_y    (ghost_y[g*Y_W +: Y_W])
            );
        end
    endgenerate

    // Compares against the walker outputs
    ghost_collision ghost_collision_inst (
        .clock    (clock),
        .resetn   (resetn),
        .check    (check),
        .player_x (player_x),
        .player_y (player_y),
        .ghost_x  (ghost_x),
        .ghost_y  (ghost_y),
        .collided (collided)
    );

endmodule

// File: source/pacman_pkg.sv
package pacman_pkg;

    // Grid size in tiles
    localparam int MAZE_W = 29;
    localparam int MAZE_H = 13;

    localparam int X_W = 5;   // Column 0..28
    localparam int Y_W = 4;   // Row 0..12

    // Direction codes, same as the keyboard decoder
    localparam int DIR_W = 3;
    localparam logic [DIR_W-1:0] DIR_UP    = 3'd1;
    localparam logic [DIR_W-1:0] DIR_LEFT  = 3'd2;
    localparam logic [DIR_W-1:0] DIR_DOWN  = 3'd3;
    localparam logic [DIR_W-1:0] DIR_RIGHT = 3'd4;

    // Player spawn tile
    localparam logic [X_W-1:0] PLAYER_START_X = 5'd1;
    localparam logic [Y_W-1:0] PLAYER_START_Y = 4'd1;

    // Ghost path tables, all packed into one file
    localparam int NUM_GHOSTS = 3;
    localparam int PATH_LEN [NUM_GHOSTS]  = '{24, 32, 20};
    localparam int PATH_BASE [NUM_GHOSTS] = '{0, 24, 56};   // Running sum of lengths
    localparam int PATH_DEPTH  = 76;
    localparam int PATH_ADDR_W = 7;   // Covers PATH_DEPTH
    localparam int IDX_W       = 5;   // Longest path is 32
    localparam string PATH_FILE = "source/ghost_paths.mem";

    // Step sequencer phases
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [ST_W-1:0] ST_STEP   = 2'd1;   // Player and indices move
    localparam logic [ST_W-1:0] ST_SETTLE = 2'd2;   // Path words reload
    localparam logic [ST_W-1:0] ST_CHECK  = 2'd3;   // Collision compare

    // One path word, raw for loading, fields for decoding
    typedef union packed {
        logic [X_W+Y_W+1:0] raw;
        struct packed {
            logic [X_W-1:0] x;   // Top 5 bits
            logic [Y_W-1:0] y;
            logic [1:0]     spare;   // Ignored
        } f;
    } path_word_t;

endpackage

// File: source/player_mover.sv
`timescale 1ns/100ps

module player_mover (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         move,
    input  logic [pacman_pkg::DIR_W-1:0] direction,
    output logic [pacman_pkg::X_W-1:0]   player_x,
    output logic [pacman_pkg::Y_W-1:0]   player_y
);

    import pacman_pkg::*;

    // Border flags, player never leaves the grid
    logic at_top;
    logic at_bottom;
    logic at_left;
    logic at_right;

    assign at_top    = (player_y == '0);
    assign at_bottom = (player_y == Y_W'(MAZE_H - 1));
    assign at_left   = (player_x == '0);
    assign at_right  = (player_x == X_W'(MAZE_W - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            player_x <= PLAYER_START_X;
            player_y <= PLAYER_START_Y;
        end else if (move) begin
            case (direction)
                DIR_UP: begin
                    if (!at_top) player_y <= player_y - 1'b1;
                end
                DIR_DOWN: begin
                    if (!at_bottom) player_y <= player_y + 1'b1;
                end
                DIR_LEFT: begin
                    if (!at_left) player_x <= player_x - 1'b1;
                end
                DIR_RIGHT: begin
                    if (!at_right) player_x <= player_x + 1'b1;
                end
                default: begin
                    // Codes 0, 5..7 keep the tile
                    player_x <= player_x;
                    player_y <= player_y;
                end
            endcase
        end
    end

endmodule

// File: verif/tb_pacman_tests.svh
// Directed tests on pacman_core_inst, checked against the model

task automatic check_reset_state();
    compare_value("reset", "step_done", 0, int'(step_done));
    check_state("reset");   // Player (1,1), ghosts at entry 0
endtask

// Several steps in one direction, checked after each
task automatic repeat_steps(input string test, input logic [DIR_W-1:0] dir, input int n);
    for (int i = 0; i < n; i++) begin
        run_step(test, dir);
        check_state(test);
    end
endtask

// Drive into all four borders and hold there
task automatic move_and_clamp();
    repeat_steps("clamp_up", DIR_UP, 3);
    compare_value("clamp_up", "player_y at top", 0, int'(player_y));
    repeat_steps("clamp_left", DIR_LEFT, 3);
    compare_value("clamp_left", "player_x at left", 0, int'(player_x));
    repeat_steps("clamp_down", DIR_DOWN, MAZE_H + 2);   // Two extra pushes
    compare_value("clamp_down", "player_y at bottom", MAZE_H - 1, int'(player_y));
    repeat_steps("clamp_right", DIR_RIGHT, MAZE_W + 2);
    compare_value("clamp_right", "player_x at right", MAZE_W - 1, int'(player_x));
    repeat_steps("clamp_up", DIR_UP, MAZE_H + 2);
    repeat_steps("clamp_left", DIR_LEFT, MAZE_W + 2);   // Back at (0,0)
endtask

// Codes outside 1..4 never move the player
task automatic hold_on_bad_codes();
    logic [DIR_W-1:0] bad_codes [4];
    int               start_x;
    int               start_y;
    bad_codes = '{3'd0, 3'd5, 3'd6, 3'd7};
    repeat_steps("bad_code", DIR_DOWN, 3);    // Off the corner first
    repeat_steps("bad_code", DIR_RIGHT, 4);
    start_x = model_x;
    start_y = model_y;
    foreach (bad_codes[i]) begin
        repeat_steps($sformatf("bad_code_%0d", bad_codes[i]), bad_codes[i], 3);
        compare_value("bad_code", "player_x held", start_x, int'(player_x));
        compare_value("bad_code", "player_y held", start_y, int'(player_y));
    end
endtask

// Long enough for every loop to wrap
task automatic walk_ghost_loops();
    path_word_t first;
    for (int g = 0; g < NUM_GHOSTS; g++)
        wrap_count[g] = 0;
    for (int s = 0; s < 70; s++) begin   // Player parked
        run_step("ghost_wrap", DIR_NONE);
        check_state("ghost_wrap");
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            first = model_paths[PATH_BASE[g]];
            // DUT back on entry 0 right after the wrap
            if (model_idx[g] == 0 && ghost_x[g*X_W +: X_W] == first.f.x &&
                ghost_y[g*Y_W +: Y_W] == first.f.y)
                wrap_count[g]++;
        end
    end
    for (int g = 0; g < NUM_GHOSTS; g++) begin
        if (wrap_count[g] == 0) begin
            failure_count++;
            $display("ghost_wrap: ghost %0d never came back to its first entry", g);
        end
    end
endtask

task automatic chase_collisions();
    logic [DIR_W-1:0] dir;
    path_word_t       target;
    int               hits;   // Collisions the DUT reported
    int               guard;
    hits = 0;
    for (int i = 0; i < 200; i++) begin
        dir = DIR_W'({$random(seed)} % 5);   // Codes 0..4
        run_step("collision_random", dir);
        check_state("collision_random");
        if (collided) hits++;
    end
    // Walk onto ghost 2's first tile
    target = model_paths[PATH_BASE[2]];
    guard  = 0;
    while ((model_x != int'(target.f.x) || model_y != int'(target.f.y)) &&
           guard < MAZE_W + MAZE_H) begin
        if (model_x < int'(target.f.x))
            dir = DIR_RIGHT;
        else if (model_x > int'(target.f.x))
            dir = DIR_LEFT;
        else if (model_y < int'(target.f.y))
            dir = DIR_DOWN;
        else
            dir = DIR_UP;
        run_step("collision_steer", dir);
        check_state("collision_steer");
        if (collided) hits++;
        guard++;
    end
    // Ghost 2 comes round within one loop
    guard = 0;
    while (!model_collided && guard < PATH_LEN[2]) begin
        run_step("collision_wait", DIR_NONE);
        check_state("collision_wait");
        guard++;
    end
    if (collided) hits++;
    if (hits == 0) begin
        failure_count++;
        $display("collision: the player never shared a tile with a ghost");
    end
endtask

// Second tick lands while the first step runs
task automatic ignore_busy_tick();
    int pulses;
    pulses    = 0;
    direction = DIR_RIGHT;
    tick      = 1'b1;
    advance_cycle();   // Accepted at this edge
    advance_cycle();   // Sampled again in the step phase
    tick = 1'b0;
    for (int i = 0; i < STEP_TIMEOUT; i++) begin
        if (step_done) pulses++;
        advance_cycle();
    end
    compare_value("busy_tick", "step_done pulses", 1, pulses);
    model_step(DIR_RIGHT);   // One step only
    check_state("busy_tick");
endtask

// File: verif/tb_pacman_core.sv
`timescale 1ns/100ps

module tb_pacman_core;

    import pacman_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;   // Inputs change after the edge
    localparam int RESET_CYCLES = 8;
    localparam int STEP_TIMEOUT = 20;   // Cycles allowed per step
    localparam int STEP_CYCLES  = 3;    // Tick edge to step_done
    localparam logic [DIR_W-1:0] DIR_NONE = '0;

    logic                      clock;
    logic                      resetn;
    logic                      tick;
    logic [DIR_W-1:0]          direction;
    logic [X_W-1:0]            player_x;
    logic [Y_W-1:0]            player_y;
    logic [NUM_GHOSTS*X_W-1:0] ghost_x;   // Ghost 0 low
    logic [NUM_GHOSTS*Y_W-1:0] ghost_y;
    logic                      collided;
    logic                      step_done;

    // Reference model state
    path_word_t model_paths [PATH_DEPTH];   // Same file as the walkers
    int         model_x;
    int         model_y;
    int         model_idx [NUM_GHOSTS];
    int         wrap_count [NUM_GHOSTS];    // Wraps seen on the DUT per ghost
    bit         model_collided;

    int seed;
    int check_count;
    int mismatch_count;
    int failure_count;   // Timeouts and other failures

    pacman_core pacman_core_inst (
        .clock     (clock),
        .resetn    (resetn),
        .tick      (tick),
        .direction (direction),
        .player_x  (player_x),
        .player_y  (player_y),
        .ghost_x   (ghost_x),
        .ghost_y   (ghost_y),
        .collided  (collided),
        .step_done (step_done)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Drive and sample point, just after the rising edge
    task automatic advance_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic compare_value(input string test, input string what,
                                 input int expected, input int actual);
        check_count++;
        if (actual != expected) begin
            mismatch_count++;
            $display("mismatch %s %s: expected %0d, actual %0d",
                     test, what, expected, actual);
        end
    endtask

    task automatic model_reset();
        model_x        = 1;   // Spawn tile (1,1)
        model_y        = 1;
        model_collided = 1'b0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            model_idx[g]  = 0;
            wrap_count[g] = 0;
        end
    endtask

    // Player on any ghost tile of the model
    function automatic bit model_hit();
        path_word_t word;
        bit         hit;
        hit = 1'b0;
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            word = model_paths[PATH_BASE[g] + model_idx[g]];
            if (int'(word.f.x) == model_x && int'(word.f.y) == model_y)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // One game step of the model, clamped at the grid border
    task automatic model_step(input logic [DIR_W-1:0] dir);
        case (dir)
            DIR_UP:    if (model_y > 0) model_y--;
            DIR_DOWN:  if (model_y < MAZE_H - 1) model_y++;
            DIR_LEFT:  if (model_x > 0) model_x--;
            DIR_RIGHT: if (model_x < MAZE_W - 1) model_x++;
            default:   ;   // Tile held
        endcase
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            if (model_idx[g] == PATH_LEN[g] - 1) begin
                model_idx[g] = 0;
            end else begin
                model_idx[g]++;
            end
        end
        model_collided = model_hit();
    endtask

    task automatic check_state(input string test);
        path_word_t word;
        compare_value(test, "player_x", model_x, int'(player_x));
        compare_value(test, "player_y", model_y, int'(player_y));
        for (int g = 0; g < NUM_GHOSTS; g++) begin
            word = model_paths[PATH_BASE[g] + model_idx[g]];
            compare_value(test, $sformatf("ghost%0d_x", g), int'(word.f.x),
                          int'(ghost_x[g*X_W +: X_W]));
            compare_value(test, $sformatf("ghost%0d_y", g), int'(word.f.y),
                          int'(ghost_y[g*Y_W +: Y_W]));
        end
        compare_value(test, "collided", int'(model_collided), int'(collided));
    endtask

    // Pulse tick, wait for step_done, then advance the model
    task automatic run_step(input string test, input logic [DIR_W-1:0] dir);
        int cycles;
        bit done;
        cycles    = 0;
        done      = 1'b0;
        direction = dir;   // Held through the whole step
        tick      = 1'b1;
        advance_cycle();
        tick = 1'b0;
        while (!done && cycles < STEP_TIMEOUT) begin
            advance_cycle();
            cycles++;
            done = step_done;
        end
        if (!done) begin
            failure_count++;
            $display("%s: no step_done within %0d cycles of the tick", test, STEP_TIMEOUT);
        end else begin
            compare_value(test, "step cycles", STEP_CYCLES, cycles);
        end
        model_step(dir);
    endtask

    `include "tb_pacman_tests.svh"

    initial begin
        seed           = 37;
        check_count    = 0;
        mismatch_count = 0;
        failure_count  = 0;
        resetn         = 1'b0;
        tick           = 1'b0;
        direction      = DIR_NONE;
        $readmemh(PATH_FILE, model_paths);
        model_reset();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        resetn = 1'b1;
        advance_cycle();
        advance_cycle();   // Walker words valid from here
        check_reset_state();
        move_and_clamp();
        hold_on_bad_codes();
        walk_ghost_loops();
        chase_collisions();
        ignore_busy_tick();
        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
